// File: rtl/fetch_pkg.sv
/* Shared definitions of the instruction fetch stage
   Widths, next-PC source encoding and the structs passed between fetch blocks */
`default_nettype none

package fetch_pkg;

  // Address and instruction width
  localparam int unsigned XLEN = 32;

  // Interrupt index width, used for vectored traps
  localparam int unsigned IRQ_ID_W = 5;

  // mtvec base field, sits above 7 zero bits
  localparam int unsigned MTVEC_BASE_W = 25;

  // NOP (addi x0,x0,0) held in IF/ID after reset and on bus errors
  localparam logic [XLEN-1:0] INSTR_RESET_VAL = 32'h0000_0013;

  // Next-PC source
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Commands from the controller
  typedef struct packed {
    logic                pc_set;
    pc_mux_e             pc_mux;
    logic [IRQ_ID_W-1:0] irq_id;
    logic                halt_if;
    logic                kill_if;
  } fetch_ctrl_t;

  // Candidate redirect addresses
  typedef struct packed {
    logic [XLEN-1:0]         boot_addr;
    logic [XLEN-1:0]         jump_target;
    logic [XLEN-1:0]         branch_target;
    logic [XLEN-1:0]         mepc;
    logic [MTVEC_BASE_W-1:0] mtvec_base;
  } pc_targets_t;

  // One fetched word with its address
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] instr;
    logic            bus_err;
  } fetch_entry_t;

  // IF/ID pipeline register as seen by decode
  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic            bus_err;
  } if_id_pipe_t;

endpackage

`default_nettype wire

// File: rtl/next_pc_mux.sv
/* Next-PC selection
   Picks the redirect address from the PC source and flags mtvec init on boot */
`timescale 1ns/1ns
`default_nettype none

module next_pc_mux (
  input  wire fetch_pkg::fetch_ctrl_t  ctrl_i,
  input  wire fetch_pkg::pc_targets_t  targets_i,
  output logic [fetch_pkg::XLEN-1:0]   branch_addr_o,
  output logic                         csr_mtvec_init_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Redirect address
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Boot target unless the source says otherwise
    branch_addr_o = {targets_i.boot_addr[fetch_pkg::XLEN-1:2], 2'b00};

    case (ctrl_i.pc_mux)
      fetch_pkg::PC_BOOT: begin
        // Word aligned boot entry
        branch_addr_o = {targets_i.boot_addr[fetch_pkg::XLEN-1:2], 2'b00};
      end
      fetch_pkg::PC_JUMP: begin
        branch_addr_o = targets_i.jump_target;
      end
      fetch_pkg::PC_BRANCH: begin
        branch_addr_o = targets_i.branch_target;
      end
      fetch_pkg::PC_MRET: begin
        // Return to the interrupted instruction
        branch_addr_o = targets_i.mepc;
      end
      fetch_pkg::PC_TRAP_EXC: begin
        // All exceptions share the base
        branch_addr_o = {targets_i.mtvec_base, 7'h00};
      end
      fetch_pkg::PC_TRAP_IRQ: begin
        // Vectored, base plus 4 * irq_id
        branch_addr_o = {targets_i.mtvec_base, ctrl_i.irq_id, 2'b00};
      end
      default: begin
        branch_addr_o = {targets_i.boot_addr[fetch_pkg::XLEN-1:2], 2'b00};
      end
    endcase
  end

  // CSR file loads mtvec when the core boots
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == fetch_pkg::PC_BOOT);

endmodule

`default_nettype wire

// File: rtl/wb_fetcher.sv
/* Wishbone classic instruction fetcher
   Holds the fetch PC, runs single read cycles and drops data of stale PCs */
`timescale 1ns/1ns
`default_nettype none

module wb_fetcher #(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,

  // Redirect from the controller
  input  wire logic                          pc_set_i,
  input  wire logic [fetch_pkg::XLEN-1:0]    branch_addr_i,

  // Queue side
  input  wire logic                          queue_full_i,
  input  wire logic                          queue_not_empty_i,
  output logic                               reserve_o,
  output logic                               push_o,
  output fetch_pkg::fetch_entry_t            push_entry_o,

  // Wishbone classic master, read only
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic [fetch_pkg::XLEN-1:0]         wb_adr_o,
  input  wire logic [fetch_pkg::XLEN-1:0]    wb_dat_i,
  input  wire logic                          wb_ack_i,
  input  wire logic                          wb_err_i,

  output logic                               busy_o
);

  localparam logic [fetch_pkg::XLEN-1:0] PC_STEP = 'd4;

  // Queue sizing is only meaningful in this range
  if ((FIFO_DEPTH < 2) || (FIFO_DEPTH > 8)) begin : gen_depth_check
    $error("wb_fetcher: FIFO_DEPTH out of range 2..8");
  end

  // Fetch PC, address of the next word to be delivered
  logic [fetch_pkg::XLEN-1:0] pc_q;
  // Address of the open bus cycle
  logic [fetch_pkg::XLEN-1:0] adr_q;
  logic                       cyc_q;
  // Open cycle belongs to a PC that was redirected away
  logic                       stale_q;
  // First fetch after reset takes the boot target
  logic                       boot_q;

  logic                       redirect;
  logic [fetch_pkg::XLEN-1:0] pc_next;
  logic                       start;
  logic                       done;
  logic                       live_done;

  ////////////////////////////////////////////////////////////////////////////
  // Cycle control
  ////////////////////////////////////////////////////////////////////////////

  assign redirect = pc_set_i || boot_q;
  assign pc_next  = redirect ? branch_addr_i : pc_q;

  // One cycle at a time, and only with a free slot in the queue
  assign start = !cyc_q && !queue_full_i;

  // ack or err ends the cycle
  assign done = cyc_q && (wb_ack_i || wb_err_i);

  // Data of a redirected cycle is dropped
  assign live_done = done && !stale_q && !pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= '0;
      adr_q   <= '0;
      cyc_q   <= 1'b0;
      stale_q <= 1'b0;
      boot_q  <= 1'b1;
    end else begin
      boot_q <= 1'b0;

      // Fetch PC follows redirects, else steps on every delivered word
      if (redirect) begin
        pc_q <= branch_addr_i;
      end else if (live_done) begin
        pc_q <= pc_q + PC_STEP;
      end

      if (start) begin
        cyc_q   <= 1'b1;
        adr_q   <= pc_next;
        stale_q <= 1'b0;
      end else if (done) begin
        // Bus signals drop in the cycle after the response
        cyc_q   <= 1'b0;
        stale_q <= 1'b0;
      end else if (pc_set_i && cyc_q) begin
        // Finish on the bus but forget the data
        stale_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and queue outputs
  ////////////////////////////////////////////////////////////////////////////

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;

  // Slot is claimed when the cycle opens
  assign reserve_o = start;

  // Push in the same cycle as the response
  assign push_o = live_done;

  always_comb begin
    push_entry_o.addr    = adr_q;
    push_entry_o.bus_err = wb_err_i;
    // Error responses carry a NOP instead of bus data
    push_entry_o.instr   = wb_err_i ? fetch_pkg::INSTR_RESET_VAL : wb_dat_i;
  end

  assign busy_o = cyc_q || queue_not_empty_i;

endmodule

`default_nettype wire

// File: rtl/fetch_queue.sv
/* Fetch queue
   Circular buffer of fetched words, with slots reserved at bus cycle start */
`timescale 1ns/1ns
`default_nettype none

module fetch_queue #(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  input  wire logic                       flush_i,
  input  wire logic                       reserve_i,
  input  wire logic                       push_i,
  input  wire fetch_pkg::fetch_entry_t    push_entry_i,
  input  wire logic                       pop_i,

  output fetch_pkg::fetch_entry_t         head_o,
  output logic                            not_empty_o,
  output logic                            full_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX  = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(FIFO_DEPTH);

  // Entry storage
  fetch_pkg::fetch_entry_t mem_q [FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  // Entries written and not yet popped
  logic [CNT_W-1:0] held_q;
  // Held entries plus slots promised to words in flight
  logic [CNT_W-1:0] used_q;

  // Wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      held_q   <= '0;
      used_q   <= '0;
    end else if (flush_i) begin
      // Old words and their reservations go away
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      held_q   <= '0;
      // Cycle opened on the flush edge still needs its slot
      used_q   <= CNT_W'(reserve_i);
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      held_q <= held_q + CNT_W'(push_i) - CNT_W'(pop_i);
      // A push fills a slot that was already reserved
      used_q <= used_q + CNT_W'(reserve_i) - CNT_W'(pop_i);
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status and head
  ////////////////////////////////////////////////////////////////////////////

  assign head_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (held_q != '0);
  assign full_o      = (used_q == FULL_CNT);

endmodule

`default_nettype wire

// File: rtl/if_id_stage.sv
/* IF/ID pipeline stage
   Pops the fetch queue and loads the decode register under halt, kill and ready */
`timescale 1ns/1ns
`default_nettype none

module if_id_stage (
  input  wire logic                      clk,
  input  wire logic                      rst_n,

  input  wire fetch_pkg::fetch_ctrl_t    ctrl_i,

  // Queue head
  input  wire fetch_pkg::fetch_entry_t   head_i,
  input  wire logic                      not_empty_i,
  output logic                           pop_o,

  // Decode handshake
  output logic                           if_valid_o,
  input  wire logic                      id_ready_i,
  output fetch_pkg::if_id_pipe_t         if_id_pipe_o
);

  logic xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Word available and the controller lets it go
  assign if_valid_o = not_empty_i && !ctrl_i.halt_if && !ctrl_i.kill_if;

  assign xfer = if_valid_o && id_ready_i;

  // Head leaves the queue on the transfer edge
  assign pop_o = xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o.instr_valid <= 1'b0;
      if_id_pipe_o.pc          <= '0;
      if_id_pipe_o.instr       <= fetch_pkg::INSTR_RESET_VAL;
      if_id_pipe_o.bus_err     <= 1'b0;
    end else if (ctrl_i.kill_if) begin
      // Kill empties the stage regardless of decode
      if_id_pipe_o.instr_valid <= 1'b0;
    end else if (xfer) begin
      if_id_pipe_o.instr_valid <= 1'b1;
      if_id_pipe_o.pc          <= head_i.addr;
      if_id_pipe_o.instr       <= head_i.instr;
      if_id_pipe_o.bus_err     <= head_i.bus_err;
    end else if (id_ready_i) begin
      // Decode took the old word, nothing new
      if_id_pipe_o.instr_valid <= 1'b0;
    end
    // Otherwise hold while decode stalls
  end

endmodule

`default_nettype wire

// File: rtl/if_stage_top.sv
/* Instruction fetch stage top level
   Next-PC mux, Wishbone fetcher, fetch queue and IF/ID register */
`timescale 1ns/1ns
`default_nettype none

module if_stage_top #(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n,

  input  wire fetch_pkg::fetch_ctrl_t        ctrl_i,
  input  wire fetch_pkg::pc_targets_t        targets_i,

  // Wishbone classic master
  output logic                               wb_cyc_o,
  output logic                               wb_stb_o,
  output logic [fetch_pkg::XLEN-1:0]         wb_adr_o,
  input  wire logic [fetch_pkg::XLEN-1:0]    wb_dat_i,
  input  wire logic                          wb_ack_i,
  input  wire logic                          wb_err_i,

  // Decode side
  output logic                               if_valid_o,
  input  wire logic                          id_ready_i,
  output fetch_pkg::if_id_pipe_t             if_id_pipe_o,

  output logic                               csr_mtvec_init_o,
  output logic                               if_busy_o
);

  logic [fetch_pkg::XLEN-1:0] branch_addr;
  logic                       queue_full;
  logic                       queue_not_empty;
  logic                       queue_reserve;
  logic                       queue_push;
  logic                       queue_pop;
  fetch_pkg::fetch_entry_t    push_entry;
  fetch_pkg::fetch_entry_t    queue_head;

  // Redirect target, combinational
  next_pc_mux next_pc_mux_inst (
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // Producer
  wb_fetcher #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) wb_fetcher_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .pc_set_i          (ctrl_i.pc_set),
    .branch_addr_i     (branch_addr),
    .queue_full_i      (queue_full),
    .queue_not_empty_i (queue_not_empty),
    .reserve_o         (queue_reserve),
    .push_o            (queue_push),
    .push_entry_o      (push_entry),
    .wb_cyc_o          (wb_cyc_o),
    .wb_stb_o          (wb_stb_o),
    .wb_adr_o          (wb_adr_o),
    .wb_dat_i          (wb_dat_i),
    .wb_ack_i          (wb_ack_i),
    .wb_err_i          (wb_err_i),
    .busy_o            (if_busy_o)
  );

  // Buffer, flushed by every redirect
  fetch_queue #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fetch_queue_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.pc_set),
    .reserve_i    (queue_reserve),
    .push_i       (queue_push),
    .push_entry_i (push_entry),
    .pop_i        (queue_pop),
    .head_o       (queue_head),
    .not_empty_o  (queue_not_empty),
    .full_o       (queue_full)
  );

  // Consumer
  if_id_stage if_id_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .head_i       (queue_head),
    .not_empty_i  (queue_not_empty),
    .pop_o        (queue_pop),
    .if_valid_o   (if_valid_o),
    .id_ready_i   (id_ready_i),
    .if_id_pipe_o (if_id_pipe_o)
  );

endmodule

`default_nettype wire

// File: tests/wb_mem_model.sv
/* Wishbone classic memory model
   Read-only slave with pattern data, variable wait states and an error window */
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model #(
  parameter logic [31:0] DATA_PATTERN = 32'h0000_0000,
  parameter logic [31:0] ERR_FIRST    = 32'h0000_8000,
  parameter logic [31:0] ERR_LAST     = 32'h0000_80FF
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        wb_cyc_i,
  input  wire logic        wb_stb_i,
  input  wire logic [31:0] wb_adr_i,
  // Wait states for a request that starts now
  input  wire logic [1:0]  wait_i,
  output logic [31:0]      wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_err_o
);

  logic       active_q;
  logic [1:0] cnt_q;
  logic       request;
  logic       respond;

  // Open request not answered yet
  assign request = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign respond = request && (active_q ? (cnt_q == 2'd0) : (wait_i == 2'd0));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      cnt_q    <= 2'd0;
      wb_dat_o <= '0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      // Responses last one cycle
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      if (respond) begin
        active_q <= 1'b0;
        if ((wb_adr_i >= ERR_FIRST) && (wb_adr_i <= ERR_LAST)) begin
          wb_err_o <= 1'b1;
          wb_dat_o <= '0;
        end else begin
          wb_ack_o <= 1'b1;
          wb_dat_o <= wb_adr_i ^ DATA_PATTERN;
        end
      end else if (request) begin
        // Count down the remaining wait states
        if (active_q) begin
          cnt_q <= cnt_q - 2'd1;
        end else begin
          active_q <= 1'b1;
          cnt_q    <= wait_i - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/if_stage_tb.sv
/* Testbench of the instruction fetch stage
   Redirects, bus errors, random bus waits and decode stalls, halt and kill */
`timescale 1ns/1ns
`default_nettype none

module if_stage_tb;

  localparam int unsigned FIFO_DEPTH = 3;
  localparam logic [31:0] MEM_PATTERN = 32'hA5C3_5A3C;
  localparam logic [31:0] ERR_FIRST   = 32'h0000_8000;
  localparam logic [31:0] ERR_LAST    = 32'h0000_80FF;
  // Words taken by decode over all phases
  localparam int PLANNED = 62;
  localparam int WATCHDOG_CYCLES = PLANNED * 200 + 8;

  logic                   clk = 1'b0;
  logic                   rst_n;
  fetch_pkg::fetch_ctrl_t ctrl;
  fetch_pkg::pc_targets_t targets;
  logic                   id_ready = 1'b0;
  logic                   ready_rand = 1'b0;
  logic [1:0]             wait_cycles = 2'd0;
  logic [15:0]            lfsr = 16'd62;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_ack;
  logic                   wb_err;
  logic [31:0]            wb_adr;
  logic [31:0]            wb_dat;
  logic                   if_valid;
  logic                   mtvec_init;
  logic                   if_busy;
  fetch_pkg::if_id_pipe_t pipe;

  // Reference state of the compare process
  logic [31:0]            exp_pc;
  fetch_pkg::if_id_pipe_t prev_pipe;
  logic                   prev_ready;
  logic                   prev_halt;
  logic                   prev_kill;
  int                     delivered = 0;
  int                     checks = 0;
  int                     errors = 0;

  always #10 clk = ~clk;

  if_stage_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) if_stage_top_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl),
    .targets_i        (targets),
    .wb_cyc_o         (wb_cyc),
    .wb_stb_o         (wb_stb),
    .wb_adr_o         (wb_adr),
    .wb_dat_i         (wb_dat),
    .wb_ack_i         (wb_ack),
    .wb_err_i         (wb_err),
    .if_valid_o       (if_valid),
    .id_ready_i       (id_ready),
    .if_id_pipe_o     (pipe),
    .csr_mtvec_init_o (mtvec_init),
    .if_busy_o        (if_busy)
  );

  wb_mem_model #(
    .DATA_PATTERN (MEM_PATTERN),
    .ERR_FIRST    (ERR_FIRST),
    .ERR_LAST     (ERR_LAST)
  ) wb_mem_model_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_adr_i (wb_adr),
    .wait_i   (wait_cycles),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference functions and helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_PATTERN;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_FIRST) && (addr <= ERR_LAST);
  endfunction

  // Where a redirect lands
  function automatic logic [31:0] expected_target(input fetch_pkg::fetch_ctrl_t c,
                                                  input fetch_pkg::pc_targets_t t);
    logic [31:0] base;
    base = {7'd0, t.mtvec_base} << 7;
    case (c.pc_mux)
      fetch_pkg::PC_JUMP:     return t.jump_target;
      fetch_pkg::PC_BRANCH:   return t.branch_target;
      fetch_pkg::PC_MRET:     return t.mepc;
      fetch_pkg::PC_TRAP_EXC: return base;
      fetch_pkg::PC_TRAP_IRQ: return base + 32'(c.irq_id) * 4;
      default:                return t.boot_addr & ~32'd3;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // One redirect cycle that also kills the word in IF/ID
  task automatic redirect(input fetch_pkg::pc_mux_e src, input logic [4:0] irq);
    @(posedge clk);
    ctrl.pc_set  <= 1'b1;
    ctrl.pc_mux  <= src;
    ctrl.irq_id  <= irq;
    ctrl.kill_if <= 1'b1;
    @(posedge clk);
    ctrl.pc_set  <= 1'b0;
    ctrl.pc_mux  <= fetch_pkg::PC_BOOT;
    ctrl.kill_if <= 1'b0;
  endtask

  task automatic wait_words(input int n);
    int target;
    target = delivered + n;
    while (delivered < target) begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Random bus waits and decode ready
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    wait_cycles <= {lfsr_bit(), lfsr_bit()};
    if (ready_rand) begin
      id_ready <= lfsr_bit();
    end else begin
      id_ready <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare process sampling mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    // mtvec init only with a boot redirect
    compare_value("csr_mtvec_init_o", mtvec_init,
                  ctrl.pc_set && (ctrl.pc_mux == fetch_pkg::PC_BOOT));
    if (!rst_n) begin
      exp_pc     = targets.boot_addr & ~32'd3;
      prev_pipe  = '0;
      prev_ready = 1'b0;
      prev_halt  = 1'b0;
      prev_kill  = 1'b0;
    end else begin
      // Halt and kill both hold the stage valid low
      if (ctrl.halt_if || ctrl.kill_if) begin
        compare_value("if_valid_o in halt or kill", if_valid, 32'd0);
      end
      if (prev_kill) begin
        compare_value("if_id_pipe_o.instr_valid after kill", pipe.instr_valid, 32'd0);
      end else if (prev_pipe.instr_valid && !prev_ready) begin
        // Register holds while decode stalls
        compare_value("if_id_pipe_o.instr_valid held", pipe.instr_valid, 32'd1);
        compare_value("if_id_pipe_o.pc held", pipe.pc, prev_pipe.pc);
        compare_value("if_id_pipe_o.instr held", pipe.instr, prev_pipe.instr);
        compare_value("if_id_pipe_o.bus_err held", pipe.bus_err, prev_pipe.bus_err);
      end else if (prev_halt) begin
        compare_value("if_id_pipe_o.instr_valid in halt", pipe.instr_valid, 32'd0);
      end
      // Decode takes the word on the coming edge
      if (pipe.instr_valid && id_ready && !ctrl.kill_if) begin
        compare_value("if_id_pipe_o.pc", pipe.pc, exp_pc);
        compare_value("if_id_pipe_o.bus_err", pipe.bus_err, in_err_window(exp_pc));
        compare_value("if_id_pipe_o.instr", pipe.instr,
                      in_err_window(exp_pc) ? fetch_pkg::INSTR_RESET_VAL : mem_word(exp_pc));
        exp_pc = exp_pc + 32'd4;
        delivered++;
      end
      if (ctrl.pc_set) begin
        exp_pc = expected_target(ctrl, targets);
      end
      prev_pipe  = pipe;
      prev_ready = id_ready;
      prev_halt  = ctrl.halt_if;
      prev_kill  = ctrl.kill_if;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n                 = 1'b0;
    ctrl                  = '0;
    ctrl.pc_mux           = fetch_pkg::PC_BOOT;
    targets.boot_addr     = 32'h0000_1002;
    // Runs into the error window after four words
    targets.jump_target   = 32'h0000_7FF0;
    targets.branch_target = 32'h0000_3000;
    targets.mepc          = 32'h0000_4004;
    // Trap base 0x5000
    targets.mtvec_base    = 25'h00_00A0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("wb_cyc_o after reset", wb_cyc, 32'd0);
    compare_value("wb_stb_o after reset", wb_stb, 32'd0);
    compare_value("if_busy_o after reset", if_busy, 32'd0);
    compare_value("if_valid_o after reset", if_valid, 32'd0);
    compare_value("if_id_pipe_o.instr_valid after reset", pipe.instr_valid, 32'd0);
    @(negedge clk);
    compare_value("wb_cyc_o first fetch", wb_cyc, 32'd1);
    compare_value("wb_stb_o first fetch", wb_stb, 32'd1);
    compare_value("wb_adr_o first fetch", wb_adr, 32'h0000_1000);
    compare_value("if_busy_o first fetch", if_busy, 32'd1);
    wait_words(12);

    // Random decode stalls from here on
    ready_rand <= 1'b1;
    redirect(fetch_pkg::PC_JUMP, 5'd0);
    wait_words(10);
    redirect(fetch_pkg::PC_BRANCH, 5'd0);
    wait_words(6);
    redirect(fetch_pkg::PC_MRET, 5'd0);
    wait_words(6);
    redirect(fetch_pkg::PC_TRAP_EXC, 5'd0);
    wait_words(6);
    redirect(fetch_pkg::PC_TRAP_IRQ, 5'd5);
    wait_words(6);
    redirect(fetch_pkg::PC_BOOT, 5'd0);
    wait_words(6);

    // Halt window
    @(posedge clk);
    ctrl.halt_if <= 1'b1;
    repeat (10) @(posedge clk);
    ctrl.halt_if <= 1'b0;
    wait_words(4);

    // Kill pulse directly followed by a redirect
    @(posedge clk);
    ctrl.kill_if <= 1'b1;
    redirect(fetch_pkg::PC_BRANCH, 5'd0);
    wait_words(6);
    repeat (4) @(posedge clk);

    $display("Checks: %0d, mismatches: %0d, words delivered: %0d",
             checks, errors, delivered);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: decode received %0d of %0d expected words, %0d mismatches",
             delivered, PLANNED, errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rtl/fetch_pkg.sv
rtl/next_pc_mux.sv
rtl/wb_fetcher.sv
rtl/fetch_queue.sv
rtl/if_id_stage.sv
rtl/if_stage_top.sv
tests/wb_mem_model.sv
tests/if_stage_tb.sv
